// ==== design/hello_pkg.sv ====
// Shared widths, register map defaults and bus channel state types
package hello_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  parameter int ADDR_W = 32;
  parameter int DATA_W = 32;

  // Virtual LED and DIP switch count
  parameter int VLED_W = 16;

  // ------------------------------
  // Register map
  // ------------------------------
  parameter logic [ADDR_W-1:0] HELLO_WORLD_ADDR_DEF = 32'h0000_0500;
  parameter logic [ADDR_W-1:0] VLED_ADDR_DEF        = 32'h0000_0504;

  // Returned for any address outside the map
  parameter logic [DATA_W-1:0] UNIMPLEMENTED_VALUE  = 32'hdead_dead;

  // ------------------------------
  // Channel states
  // ------------------------------
  // Write side, one transaction in flight at a time
  typedef enum logic [1:0] {
    WR_IDLE = 2'd0,
    WR_DATA = 2'd1,
    WR_RESP = 2'd2
  } wr_state_t;

  // Read side, lookup stage sits between capture and response
  typedef enum logic [1:0] {
    RD_IDLE   = 2'd0,
    RD_LOOKUP = 2'd1,
    RD_RESP   = 2'd2
  } rd_state_t;

endpackage

// ==== design/ocl_write_channel.sv ====
// Write address and data acceptance, register write strobe and write response FSM
`timescale 1ns/1ps

module ocl_write_channel
  import hello_pkg::*;
(
  input  logic              clk_main_a0,
  input  logic              rst_main_n_sync,
  input  logic              awvalid,
  input  logic [ADDR_W-1:0] awaddr,
  output logic              awready,
  input  logic              wvalid,
  input  logic [DATA_W-1:0] wdata,
  output logic              wready,
  output logic              bvalid,
  input  logic              bready,
  output logic              reg_wr_en,
  output logic [ADDR_W-1:0] reg_wr_addr,
  output logic [DATA_W-1:0] reg_wr_data
);

  wr_state_t         state;
  logic [ADDR_W-1:0] wr_addr_q;

  // ------------------------------
  // Handshake outputs
  // ------------------------------
  assign awready = (state == WR_IDLE);
  assign wready  = (state == WR_DATA) && wvalid;
  assign bvalid  = (state == WR_RESP);

  // Register file write happens in the wready cycle
  assign reg_wr_en   = wready;
  assign reg_wr_addr = wr_addr_q;
  assign reg_wr_data = wdata;

  // ------------------------------
  // State machine
  // ------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      state <= WR_IDLE;
    end else begin
      unique case (state)
        WR_IDLE: if (awvalid) state <= WR_DATA;
        WR_DATA: if (wvalid)  state <= WR_RESP;
        WR_RESP: if (bready)  state <= WR_IDLE;
        default:              state <= WR_IDLE;
      endcase
    end
  end

  // Address held for the data phase
  always_ff @(posedge clk_main_a0) begin
    if (awvalid && awready) begin
      wr_addr_q <= awaddr;
    end
  end

  // ------------------------------
  // Protocol checks
  // ------------------------------
  // Response must wait for the host
  a_bvalid_held : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    bvalid && !bready |=> bvalid);

  // Accepted data always answered on the next cycle
  a_wready_resp : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    wready |=> bvalid);

endmodule

// ==== design/ocl_read_channel.sv ====
// Read address capture, register lookup stage and read response FSM
`timescale 1ns/1ps

module ocl_read_channel
  import hello_pkg::*;
(
  input  logic              clk_main_a0,
  input  logic              rst_main_n_sync,
  input  logic              arvalid,
  input  logic [ADDR_W-1:0] araddr,
  output logic              arready,
  output logic              rvalid,
  output logic [DATA_W-1:0] rdata,
  input  logic              rready,
  output logic [ADDR_W-1:0] rd_addr,
  input  logic [DATA_W-1:0] rd_data
);

  rd_state_t         state;
  logic [ADDR_W-1:0] rd_addr_q;
  logic [DATA_W-1:0] rdata_q;

  // ------------------------------
  // Handshake outputs
  // ------------------------------
  assign arready = (state == RD_IDLE);
  assign rvalid  = (state == RD_RESP);
  assign rdata   = rdata_q;

  // Captured address drives the register file decode
  assign rd_addr = rd_addr_q;

  // ------------------------------
  // State machine
  // ------------------------------
  // IDLE -> LOOKUP -> RESP, response held until rready
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      state <= RD_IDLE;
    end else begin
      unique case (state)
        RD_IDLE: begin
          if (arvalid) begin
            state <= RD_LOOKUP;
          end
        end
        RD_LOOKUP: begin
          state <= RD_RESP;
        end
        RD_RESP: begin
          if (rready) begin
            state <= RD_IDLE;
          end
        end
        default: begin
          state <= RD_IDLE;
        end
      endcase
    end
  end

  // ------------------------------
  // Address and data registers
  // ------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (arvalid && arready) begin
      rd_addr_q <= araddr;
    end
  end

  // Lookup result is sampled once, then held for the host
  always_ff @(posedge clk_main_a0) begin
    if (state == RD_LOOKUP) begin
      rdata_q <= rd_data;
    end
  end

  // ------------------------------
  // Protocol checks
  // ------------------------------
  // Stalled response keeps valid and data
  a_rdata_stable : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

// ==== design/hello_world_regs.sv ====
// Hello world register, byte-swapped read view, LED shadow and read decode
`timescale 1ns/1ps

module hello_world_regs
  import hello_pkg::*;
#(
  parameter logic [ADDR_W-1:0] HELLO_WORLD_ADDR = HELLO_WORLD_ADDR_DEF,
  parameter logic [ADDR_W-1:0] VLED_ADDR        = VLED_ADDR_DEF
) (
  input  logic              clk_main_a0,
  input  logic              rst_main_n_sync,
  input  logic              reg_wr_en,
  input  logic [ADDR_W-1:0] reg_wr_addr,
  input  logic [DATA_W-1:0] reg_wr_data,
  input  logic [ADDR_W-1:0] rd_addr,
  output logic [DATA_W-1:0] rd_data,
  output logic [VLED_W-1:0] led_shadow
);

  logic [DATA_W-1:0] hello_world_q;
  logic [DATA_W-1:0] hello_world_swapped;

  // ------------------------------
  // Hello world register
  // ------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      hello_world_q <= '0;
    end else if (reg_wr_en && (reg_wr_addr == HELLO_WORLD_ADDR)) begin
      hello_world_q <= reg_wr_data;
    end
  end

  // Reads come back with byte order reversed
  assign hello_world_swapped = {hello_world_q[7:0],   hello_world_q[15:8],
                                hello_world_q[23:16], hello_world_q[31:24]};

  // LED shadow lags the register by one cycle
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      led_shadow <= '0;
    end else begin
      led_shadow <= hello_world_q[VLED_W-1:0];
    end
  end

  // ------------------------------
  // Read decode
  // ------------------------------
  always_comb begin
    if (rd_addr == HELLO_WORLD_ADDR) begin
      rd_data = hello_world_swapped;
    end else if (rd_addr == VLED_ADDR) begin
      rd_data = {{(DATA_W - VLED_W){1'b0}}, led_shadow};
    end else begin
      rd_data = UNIMPLEMENTED_VALUE;
    end
  end

endmodule

// ==== design/vled_status.sv ====
// Virtual DIP synchronizer, LED masking and registered LED status output
`timescale 1ns/1ps

module vled_status
  import hello_pkg::*;
(
  input  logic              clk_main_a0,
  input  logic              rst_main_n_sync,
  input  logic [VLED_W-1:0] led_shadow,
  input  logic [VLED_W-1:0] vdip,
  output logic [VLED_W-1:0] vled
);

  logic [VLED_W-1:0] vdip_q;
  logic [VLED_W-1:0] vdip_q2;
  logic [VLED_W-1:0] vled_masked;

  // ------------------------------
  // DIP synchronizer
  // ------------------------------
  // Switches change with no relation to clk_main_a0
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vdip_q  <= '0;
      vdip_q2 <= '0;
    end else begin
      vdip_q  <= vdip;
      vdip_q2 <= vdip_q;
    end
  end

  // ------------------------------
  // Masked LED output
  // ------------------------------
  // A switch that is off blanks its LED
  assign vled_masked = led_shadow & vdip_q2;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vled <= '0;
    end else begin
      vled <= vled_masked;
    end
  end

endmodule

// ==== design/cl_hello_world.sv ====
// Top level of the hello world register block with its bus channels and LED stage
`timescale 1ns/1ps

module cl_hello_world
  import hello_pkg::*;
#(
  parameter logic [ADDR_W-1:0] HELLO_WORLD_ADDR = HELLO_WORLD_ADDR_DEF,
  parameter logic [ADDR_W-1:0] VLED_ADDR        = VLED_ADDR_DEF
) (
  input  logic              clk_main_a0,
  input  logic              rst_main_n_sync,
  input  logic              ocl_awvalid,
  input  logic [ADDR_W-1:0] ocl_awaddr,
  output logic              ocl_awready,
  input  logic              ocl_wvalid,
  input  logic [DATA_W-1:0] ocl_wdata,
  output logic              ocl_wready,
  output logic              ocl_bvalid,
  input  logic              ocl_bready,
  input  logic              ocl_arvalid,
  input  logic [ADDR_W-1:0] ocl_araddr,
  output logic              ocl_arready,
  output logic              ocl_rvalid,
  output logic [DATA_W-1:0] ocl_rdata,
  input  logic              ocl_rready,
  input  logic [VLED_W-1:0] vdip,
  output logic [VLED_W-1:0] vled
);

  // Write channel to register file
  logic              reg_wr_en;
  logic [ADDR_W-1:0] reg_wr_addr;
  logic [DATA_W-1:0] reg_wr_data;

  // Read lookup
  logic [ADDR_W-1:0] rd_addr;
  logic [DATA_W-1:0] rd_data;

  logic [VLED_W-1:0] led_shadow;

  // ------------------------------
  // Bus channels
  // ------------------------------
  ocl_write_channel u_write_channel (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (ocl_awvalid),
    .awaddr          (ocl_awaddr),
    .awready         (ocl_awready),
    .wvalid          (ocl_wvalid),
    .wdata           (ocl_wdata),
    .wready          (ocl_wready),
    .bvalid          (ocl_bvalid),
    .bready          (ocl_bready),
    .reg_wr_en       (reg_wr_en),
    .reg_wr_addr     (reg_wr_addr),
    .reg_wr_data     (reg_wr_data)
  );

  ocl_read_channel u_read_channel (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .arvalid         (ocl_arvalid),
    .araddr          (ocl_araddr),
    .arready         (ocl_arready),
    .rvalid          (ocl_rvalid),
    .rdata           (ocl_rdata),
    .rready          (ocl_rready),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data)
  );

  // ------------------------------
  // Registers and LED status
  // ------------------------------
  hello_world_regs #(
    .HELLO_WORLD_ADDR (HELLO_WORLD_ADDR),
    .VLED_ADDR        (VLED_ADDR)
  ) u_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .reg_wr_en       (reg_wr_en),
    .reg_wr_addr     (reg_wr_addr),
    .reg_wr_data     (reg_wr_data),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data),
    .led_shadow      (led_shadow)
  );

  vled_status u_vled_status (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .led_shadow      (led_shadow),
    .vdip            (vdip),
    .vled            (vled)
  );

endmodule

// ==== testbench/tb_cl_hello_world.sv ====
// Clock, reset, file-driven bus transactions, protocol checks, timeout and summary
`timescale 1ns/1ps

module tb_cl_hello_world
  import hello_pkg::*;
();

  typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_DIP} op_t;

  localparam string STIM_FILE    = "testbench/hello_stimulus.txt";
  localparam int    RESET_CYCLES = 4;

  logic              clk_main_a0     = 1'b0;
  logic              rst_main_n_sync = 1'b0;
  logic              ocl_awvalid     = 1'b0;
  logic [ADDR_W-1:0] ocl_awaddr      = '0;
  logic              ocl_wvalid      = 1'b0;
  logic [DATA_W-1:0] ocl_wdata       = '0;
  logic              ocl_bready      = 1'b0;
  logic              ocl_arvalid     = 1'b0;
  logic [ADDR_W-1:0] ocl_araddr      = '0;
  logic              ocl_rready      = 1'b0;
  logic [VLED_W-1:0] vdip            = '0;
  logic              ocl_awready;
  logic              ocl_wready;
  logic              ocl_bvalid;
  logic              ocl_arready;
  logic              ocl_rvalid;
  logic [DATA_W-1:0] ocl_rdata;
  logic [VLED_W-1:0] vled;

  // Transactions loaded from the file
  op_t               op_q[$];
  logic [DATA_W-1:0] arg_q[$];
  logic [DATA_W-1:0] data_q[$];
  logic [DATA_W-1:0] exp_q[$];

  integer            seed            = 32'heab334e0;
  logic [VLED_W-1:0] led_exp         = '0;
  int                cycle_count     = 0;
  int                cycle_limit     = 1000000;
  int                check_count     = 0;
  int                error_count     = 0;
  int                protocol_errors = 0;
  int                b_count         = 0;
  int                r_count         = 0;
  int                n_writes        = 0;
  int                n_reads         = 0;

  cl_hello_world dut (.*);

  always #10 clk_main_a0 = ~clk_main_a0;

  always @(posedge clk_main_a0) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: stimulus did not complete within %0d cycles", cycle_limit);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // ------------------------------
  // Bus monitor
  // ------------------------------
  always @(posedge clk_main_a0) begin
    if (rst_main_n_sync) begin
      assert (!(ocl_bvalid && ocl_awready)) else begin
        protocol_errors++;
        $display("Protocol error at %0t: write address open while a response is pending", $time);
      end
      assert (!(ocl_rvalid && ocl_arready)) else begin
        protocol_errors++;
        $display("Protocol error at %0t: read address open while a response is pending", $time);
      end
      if (ocl_bvalid && ocl_bready) b_count++;
      if (ocl_rvalid && ocl_rready) r_count++;
    end
  end

  task automatic check_value(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                             input string what);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  function automatic logic random_ready();
    int draw;
    draw = $random(seed);
    return (draw & 3) != 0;
  endfunction

  task automatic load_stimulus();
    int          fd;
    int          n;
    string       line_str;
    string       op_word;
    logic [31:0] f_arg;
    logic [31:0] f_data;
    logic [31:0] f_exp;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("Stimulus file %s could not be opened", STIM_FILE);
      error_count++;
      return;
    end
    while ($fgets(line_str, fd) != 0) begin
      op_word = "";
      n = $sscanf(line_str, "%s %h %h %h", op_word, f_arg, f_data, f_exp);
      if (n >= 1 && op_word != "#") begin
        if (n == 4 && (op_word == "WRITE" || op_word == "READ" || op_word == "DIP")) begin
          op_q.push_back(op_word == "WRITE" ? OP_WRITE : (op_word == "READ" ? OP_READ : OP_DIP));
          arg_q.push_back(f_arg);
          data_q.push_back(f_data);
          exp_q.push_back(f_exp);
        end else begin
          $display("Stimulus line could not be parsed: %s", line_str);
          error_count++;
        end
      end
    end
    $fclose(fd);
  endtask

  // ------------------------------
  // Transactions
  // ------------------------------
  // Expected value is the LED output once the write has passed the shadow stage
  task automatic do_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                          input logic [VLED_W-1:0] exp_led);
    int edges;
    bit b_done;
    ocl_awvalid <= 1'b1;
    ocl_awaddr  <= addr;
    @(posedge clk_main_a0);
    while (!(ocl_awvalid && ocl_awready)) @(posedge clk_main_a0);
    ocl_awvalid <= 1'b0;
    ocl_wvalid  <= 1'b1;
    ocl_wdata   <= data;
    @(posedge clk_main_a0);
    while (!(ocl_wvalid && ocl_wready)) @(posedge clk_main_a0);
    ocl_wvalid <= 1'b0;
    ocl_bready <= random_ready();
    edges  = 0;
    b_done = 1'b0;
    while (!b_done || edges < 3) begin
      @(posedge clk_main_a0);
      edges++;
      if (edges == 1) check_value(DATA_W'(ocl_bvalid), 1, "bvalid one cycle after data");
      if (edges == 2) check_value(DATA_W'(vled), DATA_W'(led_exp), "vled before write settles");
      if (edges == 3) check_value(DATA_W'(vled), DATA_W'(exp_led), "vled after write");
      if (!b_done) begin
        if (ocl_bvalid && ocl_bready) begin
          b_done = 1'b1;
          ocl_bready <= 1'b1;
        end else begin
          ocl_bready <= random_ready();
        end
      end
    end
    led_exp = exp_led;
    n_writes++;
  endtask

  task automatic do_read(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp_data);
    int                edges;
    bit                r_done;
    bit                seen;
    logic [DATA_W-1:0] first_data;
    ocl_arvalid <= 1'b1;
    ocl_araddr  <= addr;
    @(posedge clk_main_a0);
    while (!(ocl_arvalid && ocl_arready)) @(posedge clk_main_a0);
    ocl_arvalid <= 1'b0;
    ocl_rready  <= random_ready();
    edges      = 0;
    r_done     = 1'b0;
    seen       = 1'b0;
    first_data = '0;
    while (!r_done) begin
      @(posedge clk_main_a0);
      edges++;
      if (edges <= 2) check_value(DATA_W'(ocl_rvalid), DATA_W'(edges == 2), "read latency");
      if (ocl_rvalid) begin
        if (!seen) first_data = ocl_rdata;
        seen = 1'b1;
        check_value(ocl_rdata, first_data, "rdata stable while stalled");
        if (ocl_rready) begin
          check_value(ocl_rdata, exp_data, $sformatf("read of address %h", addr));
          r_done = 1'b1;
        end
      end
      ocl_rready <= r_done ? 1'b1 : random_ready();
    end
    n_reads++;
  endtask

  // Two sync flops and the output register
  task automatic set_dip(input logic [VLED_W-1:0] dip, input logic [VLED_W-1:0] exp_led);
    int edges;
    vdip <= dip;
    for (edges = 1; edges <= 4; edges++) begin
      @(posedge clk_main_a0);
      if (edges == 3) check_value(DATA_W'(vled), DATA_W'(led_exp), "vled before DIP settles");
      if (edges == 4) check_value(DATA_W'(vled), DATA_W'(exp_led), "vled after DIP change");
    end
    led_exp = exp_led;
  endtask

  initial begin
    int i;
    load_stimulus();
    cycle_limit = 200 * op_q.size() + RESET_CYCLES;
    repeat (RESET_CYCLES) @(posedge clk_main_a0);
    rst_main_n_sync <= 1'b1;
    @(posedge clk_main_a0);
    check_value(DATA_W'({ocl_awready, ocl_arready, ocl_wready, ocl_bvalid, ocl_rvalid}),
                DATA_W'(5'b11000), "handshake outputs after reset");
    check_value(DATA_W'(vled), '0, "vled after reset");
    for (i = 0; i < op_q.size(); i++) begin
      case (op_q[i])
        OP_WRITE: do_write(arg_q[i], data_q[i], exp_q[i][VLED_W-1:0]);
        OP_READ:  do_read(arg_q[i], exp_q[i]);
        default:  set_dip(arg_q[i][VLED_W-1:0], exp_q[i][VLED_W-1:0]);
      endcase
    end
    @(posedge clk_main_a0);
    check_value(b_count, n_writes, "write response count");
    check_value(r_count, n_reads, "read response count");
    $display("Summary: %0d checks, %0d value errors, %0d protocol errors, %0d writes, %0d reads",
             check_count, error_count, protocol_errors, n_writes, n_reads);
    if (error_count == 0 && protocol_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== testbench/hello_stimulus.txt ====
# opcode  address/dip  data      expected (rdata for READ, vled for WRITE and DIP)
# DIP lines carry the switch value in the second column, data unused for READ and DIP
READ      00000500     00000000  00000000
READ      00000504     00000000  00000000
DIP       0000ffff     00000000  00000000
WRITE     00000500     12345678  00005678
READ      00000500     00000000  78563412
READ      00000504     00000000  00005678
READ      00000508     00000000  deaddead
READ      00000000     00000000  deaddead
DIP       000000ff     00000000  00000078
DIP       0000f0f0     00000000  00005070
WRITE     00000500     cafebabe  0000b0b0
READ      00000500     00000000  bebafeca
READ      00000504     00000000  0000babe
WRITE     00000504     ffffffff  0000b0b0
READ      00000504     00000000  0000babe
WRITE     00000600     11111111  0000b0b0
READ      00000600     00000000  deaddead
READ      00000500     00000000  bebafeca
DIP       0000ffff     00000000  0000babe
WRITE     00000500     a5a50f0f  00000f0f
READ      00000500     00000000  0f0fa5a5
DIP       00000000     00000000  00000000
WRITE     00000500     0000ffff  00000000
READ      00000504     00000000  0000ffff
DIP       00003c3c     00000000  00003c3c
WRITE     00000500     deadbeef  00003c2c
READ      00000500     00000000  efbeadde
READ      00000504     00000000  0000beef
READ      00000ffc     00000000  deaddead
WRITE     00000500     00000000  00000000
READ      00000500     00000000  00000000
READ      00000504     00000000  00000000

// ==== filelist.f ====
design/hello_pkg.sv
design/ocl_write_channel.sv
design/ocl_read_channel.sv
design/hello_world_regs.sv
design/vled_status.sv
design/cl_hello_world.sv
testbench/tb_cl_hello_world.sv

// ==== Makefile ====
# Verilator build and run of the hello world register block testbench

VERILATOR ?= verilator
TOP       ?= tb_cl_hello_world
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= STATUS: PASS

SOURCES := $(wildcard design/*.sv) $(wildcard testbench/*.sv)
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(BINARY) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
